// File: sources.f
+incdir+source
source/cache_pkg.sv
source/line_buffer.sv
source/cbus_arbiter.sv
source/burst_ram.sv
source/cache_top.sv
verif/tb_cache_top.sv

// File: Makefile
TOP = tb_cache_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module cache_top -f sources.f
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: verif/tb_cache_top.sv
`default_nettype none

`include "cache_cfg.svh"

module tb_cache_top import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 5;
    localparam int cycle_limit = 20000;
    localparam int line_words  = `CACHE_LINE_WORDS;
    localparam int ram_bits    = $clog2(`CACHE_RAM_WORDS);

    // three lines with different tags
    localparam addr_t line_a = 32'h0000_0100;
    localparam addr_t line_b = 32'h0000_0900;
    localparam addr_t line_c = 32'h0000_0500;

    logic       clk;
    logic       reset;
    sram_req_t  imem_req;
    sram_resp_t imem_resp;
    sram_req_t  dmem_req;
    sram_resp_t dmem_resp;

    // byte image of what the processor has stored
    byte_t       model [`CACHE_RAM_WORDS * 4];
    bit          known [`CACHE_RAM_WORDS * 4];

    logic [31:0] lfsr_state = 32'd75;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       test;

    cache_top u_cache_top (
        .clk       (clk),
        .reset     (reset),
        .imem_req  (imem_req),
        .imem_resp (imem_resp),
        .dmem_req  (dmem_req),
        .dmem_resp (dmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // bound on the whole run
    always @(posedge clk) begin
        cycles++;
        if (cycles == cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("sim failed");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // byte lanes written by a store of this size
    function automatic logic [3:0] lanes_for(access_size_t size, logic [1:0] index);
        case (size)
            BYTE:    return 4'b0001 << index;
            HALF:    return index[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic drive_port(input bit instr, input sram_req_t req);
        if (instr) begin
            imem_req = req;
        end else begin
            dmem_req = req;
        end
    endtask

    // one request, held until accepted, then wait for data_ok
    task automatic access(input bit instr, input logic wr, input access_size_t size,
                          input addr_t addr, input word_t wdata,
                          output word_t rdata, output bit zero_wait);
        bit         accepted;
        bit         done;
        sram_resp_t resp;
        accepted  = 1'b0;
        done      = 1'b0;
        zero_wait = 1'b0;
        rdata     = '0;
        @(negedge clk);
        drive_port(instr, '{req: 1'b1, wr: wr, size: size, addr: addr, wdata: wdata});
        while (!done) begin
            // sample just before the rising edge
            #(half_period - 1);
            resp = instr ? imem_resp : dmem_resp;
            if (resp.data_ok && (accepted || resp.addr_ok)) begin
                done      = 1'b1;
                rdata     = resp.rdata;
                zero_wait = !accepted;
            end
            if (resp.addr_ok) begin
                accepted = 1'b1;
            end
            @(negedge clk);
            if (accepted) begin
                drive_port(instr, '0);
            end
        end
    endtask

    task automatic store(input access_size_t size, input addr_t addr, input word_t wdata);
        word_t      rdata;
        bit         zero_wait;
        logic [3:0] strb;
        int         base;
        access(1'b0, 1'b1, size, addr, wdata, rdata, zero_wait);
        strb = lanes_for(size, addr[1:0]);
        base = int'(addr[ram_bits+1:2]) * 4;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                model[base+i] = wdata[8*i +: 8];
                known[base+i] = 1'b1;
            end
        end
    endtask

    task automatic load_check(input string name, input bit instr, input addr_t addr,
                              input bit want_zero_wait);
        word_t rdata;
        word_t expected;
        bit    zero_wait;
        bit    full;
        int    base;
        access(instr, 1'b0, WORD, addr, '0, rdata, zero_wait);
        base = int'(addr[ram_bits+1:2]) * 4;
        full = 1'b1;
        for (int i = 0; i < 4; i++) begin
            full &= known[base+i];
            expected[8*i +: 8] = model[base+i];
        end
        if (full) begin
            checks++;
            assert (rdata === expected) else begin
                errors++;
                $display("CHECK FAILED %s: addr %h expected %h actual %h",
                         name, addr, expected, rdata);
            end
        end
        if (want_zero_wait) begin
            checks++;
            assert (zero_wait) else begin
                errors++;
                $display("%s: read of %h did not finish in its accept cycle", name, addr);
            end
        end
    endtask

    initial begin
        int           offset;
        int           index;
        access_size_t size;
        imem_req = '0;
        dmem_req = '0;
        reset    = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        test = "write then read hit";
        for (int w = 0; w < line_words; w++) begin
            store(WORD, line_a + addr_t'(4 * w), random_bits(32));
        end
        for (int w = 0; w < line_words; w++) begin
            load_check(test, 1'b0, line_a + addr_t'(4 * w), 1'b1);
        end

        test = "byte and half merge";
        repeat (8) begin
            offset = int'(random_bits(4));
            index  = int'(random_bits(2));
            size   = random_bits(1) ? HALF : BYTE;
            store(size, line_a + addr_t'(4 * offset + index), random_bits(32));
            load_check(test, 1'b0, line_a + addr_t'(4 * offset), 1'b1);
        end

        // line b pushes dirty line a out to the RAM
        test = "dirty eviction";
        store(WORD, line_b + addr_t'(12), random_bits(32));
        for (int w = 0; w < line_words; w++) begin
            load_check(test, 1'b0, line_a + addr_t'(4 * w), w != 0);
        end

        test = "write miss merge";
        for (int w = 0; w < 4; w++) begin
            store(WORD, line_c + addr_t'(4 * w), random_bits(32));
        end
        load_check(test, 1'b0, line_b + addr_t'(12), 1'b0);
        index = int'(random_bits(2));
        store(BYTE, line_c + addr_t'(4 + index), random_bits(32));
        for (int w = 0; w < 4; w++) begin
            load_check(test, 1'b0, line_c + addr_t'(4 * w), 1'b1);
        end

        // dmem miss with a dirty victim races an imem miss
        test = "instruction path";
        fork
            load_check(test, 1'b1, line_a + addr_t'(20), 1'b0);
            load_check(test, 1'b0, line_b + addr_t'(12), 1'b0);
        join
        for (int w = 0; w < line_words; w++) begin
            load_check(test, 1'b1, line_a + addr_t'(4 * w), 1'b1);
        end
        load_check(test, 1'b0, line_c + addr_t'(4), 1'b0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cache_top.sv
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  sram_req_t  imem_req,
    output sram_resp_t imem_resp,
    input  sram_req_t  dmem_req,
    output sram_resp_t dmem_resp
);

    cbus_req_t  i_bus_req;
    cbus_resp_t i_bus_resp;
    cbus_req_t  d_bus_req;
    cbus_resp_t d_bus_resp;
    cbus_req_t  mem_req;
    cbus_resp_t mem_resp;

    line_buffer u_ibuf (
        .clk       (clk),
        .reset     (reset),
        .sram_req  (imem_req),
        .sram_resp (imem_resp),
        .cbus_req  (i_bus_req),
        .cbus_resp (i_bus_resp)
    );

    line_buffer u_dbuf (
        .clk       (clk),
        .reset     (reset),
        .sram_req  (dmem_req),
        .sram_resp (dmem_resp),
        .cbus_req  (d_bus_req),
        .cbus_resp (d_bus_resp)
    );

    // one shared burst bus to the RAM
    cbus_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .i_bus_req  (i_bus_req),
        .i_bus_resp (i_bus_resp),
        .d_bus_req  (d_bus_req),
        .d_bus_resp (d_bus_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

    burst_ram u_ram (
        .clk      (clk),
        .reset    (reset),
        .bus_req  (mem_req),
        .bus_resp (mem_resp)
    );

endmodule

`default_nettype wire

// File: source/burst_ram.sv
`default_nettype none

`include "cache_cfg.svh"

module burst_ram import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  cbus_req_t  bus_req,
    output cbus_resp_t bus_resp
);

    typedef enum logic [1:0] {
        IDLE,
        BEAT,
        GAP
    } phase_t;

    localparam int ram_bits = $clog2(`CACHE_RAM_WORDS);

    typedef logic [ram_bits-1:0] ram_index_t;

    word_t      mem [`CACHE_RAM_WORDS];

    phase_t     phase;
    ram_index_t count;
    ram_index_t base;
    ram_index_t last_count;

    ram_index_t req_index;
    ram_index_t req_span;
    ram_index_t beat_index;
    logic       beat_last;

    // word address, upper bits alias
    assign req_index  = bus_req.addr[ram_bits+align_bits-1:align_bits];
    assign req_span   = ram_index_t'((32'd1 << bus_req.order) - 32'd1);
    assign beat_index = base + count;
    assign beat_last  = count == last_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= IDLE;
            count <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    if (bus_req.valid) begin
                        phase <= BEAT;
                        count <= '0;
                    end
                end
                BEAT: begin
                    count <= count + 1'b1;
                    if (beat_last) begin
                        phase <= GAP;
                    end
                end
                // one dead cycle between bursts
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == IDLE && bus_req.valid) begin
            base       <= req_index & ~req_span;
            last_count <= req_span;
        end
        if (phase == BEAT && bus_req.is_write) begin
            mem[beat_index] <= bus_req.wdata;
        end
    end

    assign bus_resp.okay  = phase == BEAT;
    assign bus_resp.last  = (phase == BEAT) && beat_last;
    assign bus_resp.rdata = mem[beat_index];

endmodule

`default_nettype wire

// File: source/cbus_arbiter.sv
`default_nettype none

module cbus_arbiter import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  cbus_req_t  i_bus_req,
    output cbus_resp_t i_bus_resp,
    input  cbus_req_t  d_bus_req,
    output cbus_resp_t d_bus_resp,
    output cbus_req_t  mem_req,
    input  cbus_resp_t mem_resp
);

    typedef enum logic [1:0] {
        NONE,
        INSTR,
        DATA
    } owner_t;

    owner_t owner;
    owner_t grant;

    // an idle bus is granted in the same cycle, data first
    always_comb begin
        grant = owner;
        if (owner == NONE) begin
            if (d_bus_req.valid) begin
                grant = DATA;
            end else if (i_bus_req.valid) begin
                grant = INSTR;
            end
        end
    end

    // held until the final beat is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= NONE;
        end else if (mem_resp.okay && mem_resp.last) begin
            owner <= NONE;
        end else begin
            owner <= grant;
        end
    end

    always_comb begin
        case (grant)
            DATA:    mem_req = d_bus_req;
            INSTR:   mem_req = i_bus_req;
            default: mem_req = '0;
        endcase
    end

    // the loser just sees stall beats
    always_comb begin
        i_bus_resp      = mem_resp;
        d_bus_resp      = mem_resp;
        i_bus_resp.okay = 1'b0;
        i_bus_resp.last = 1'b0;
        d_bus_resp.okay = 1'b0;
        d_bus_resp.last = 1'b0;
        if (grant == INSTR) begin
            i_bus_resp = mem_resp;
        end
        if (grant == DATA) begin
            d_bus_resp = mem_resp;
        end
    end

endmodule

`default_nettype wire

// File: source/line_buffer.sv
`default_nettype none

`include "cache_cfg.svh"

module line_buffer import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  sram_req_t  sram_req,
    output sram_resp_t sram_resp,
    output cbus_req_t  cbus_req,
    input  cbus_resp_t cbus_resp
);

    typedef view_t [`CACHE_LINE_WORDS-1:0] line_t;

    // the one cached line and its meta bits
    line_t         line_data;
    tag_t          tag;
    logic          valid;
    logic          dirty;

    buffer_state_t state;
    offset_t       offset;
    sram_req_t     saved_req;

    line_addr_t    req_addr;
    line_addr_t    saved_addr;
    strobe_t       req_strb;
    strobe_t       saved_strb;
    view_t         req_wdata;
    view_t         saved_wdata;
    view_t         fill_word;

    logic          tag_hit;
    logic          offset_hit;
    logic          hit;
    logic          miss;
    logic          beat_done;
    logic          burst_done;

    function automatic view_t merge_word(view_t old_word, view_t new_word, strobe_t strb);
        view_t merged;
        merged = old_word;
        for (int i = 0; i < bytes_per_word; i++) begin
            if (strb[i]) begin
                merged.bytes[i] = new_word.bytes[i];
            end
        end
        return merged;
    endfunction

    assign req_addr    = line_addr_t'(sram_req.addr);
    assign saved_addr  = line_addr_t'(saved_req.addr);
    assign req_strb    = size_to_strobe(sram_req.size, req_addr.index);
    assign saved_strb  = size_to_strobe(saved_req.size, saved_addr.index);
    assign req_wdata   = view_t'(sram_req.wdata);
    assign saved_wdata = view_t'(saved_req.wdata);

    assign tag_hit    = valid && (tag == req_addr.tag);
    assign offset_hit = offset == saved_addr.offset;
    assign hit        = (state == IDLE) && sram_req.req && tag_hit;
    assign miss       = (state == IDLE) && sram_req.req && !tag_hit;
    assign beat_done  = cbus_resp.okay;
    assign burst_done = cbus_resp.okay && cbus_resp.last;

    // store miss lands on top of the incoming beat
    assign fill_word = (saved_req.wr && offset_hit) ?
        merge_word(view_t'(cbus_resp.rdata), saved_wdata, saved_strb) :
        view_t'(cbus_resp.rdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            valid  <= 1'b0;
            dirty  <= 1'b0;
            offset <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (hit && sram_req.wr) begin
                        dirty <= 1'b1;
                    end
                    if (miss) begin
                        state <= dirty ? WRITE : READ;
                    end
                end
                WRITE: begin
                    // offset wraps back to zero on the last beat
                    if (beat_done) begin
                        offset <= offset + 1'b1;
                    end
                    if (burst_done) begin
                        state <= READ;
                    end
                end
                READ: begin
                    if (beat_done) begin
                        offset <= offset + 1'b1;
                    end
                    if (burst_done) begin
                        state <= IDLE;
                        valid <= 1'b1;
                        dirty <= saved_req.wr;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // line contents, tag and the pending request
    always_ff @(posedge clk) begin
        if (hit && sram_req.wr) begin
            line_data[req_addr.offset] <=
                merge_word(line_data[req_addr.offset], req_wdata, req_strb);
        end
        if (miss) begin
            saved_req <= sram_req;
        end
        if (state == READ && beat_done) begin
            line_data[offset] <= fill_word;
            if (cbus_resp.last) begin
                tag <= saved_addr.tag;
            end
        end
    end

    assign sram_resp.addr_ok = state == IDLE;
    assign sram_resp.data_ok = hit || (state == READ && offset_hit && beat_done);
    // a miss forwards the refill beat straight through
    assign sram_resp.rdata   = (state == IDLE) ?
        line_data[req_addr.offset].word : cbus_resp.rdata;

    assign cbus_req.valid    = (state == READ) || (state == WRITE);
    assign cbus_req.is_write = state == WRITE;
    assign cbus_req.order    = cbus_order_t'(`CACHE_BURST_ORDER);
    assign cbus_req.wdata    = line_data[offset].word;
    assign cbus_req.addr     = addr_t'(line_addr_t'{
        tag:    (state == WRITE) ? tag : saved_addr.tag,
        offset: '0,
        index:  '0
    });

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    localparam int bytes_per_word = `CACHE_WORD_BITS / 8;
    localparam int align_bits     = $clog2(bytes_per_word);
    localparam int tag_bits       = `CACHE_WORD_BITS - `CACHE_BURST_ORDER - align_bits;

    typedef logic [7:0]                       byte_t;
    typedef logic [`CACHE_WORD_BITS-1:0]      word_t;
    typedef logic [`CACHE_WORD_BITS-1:0]      addr_t;
    typedef logic [bytes_per_word-1:0]        strobe_t;
    typedef logic [3:0]                       cbus_order_t;
    typedef logic [tag_bits-1:0]              tag_t;
    typedef logic [`CACHE_BURST_ORDER-1:0]    offset_t;
    typedef logic [align_bits-1:0]            index_t;

    typedef union packed {
        byte_t [bytes_per_word-1:0] bytes;
        word_t                      word;
    } view_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } access_size_t;

    typedef struct packed {
        tag_t    tag;
        offset_t offset;
        index_t  index;
    } line_addr_t;

    // processor side, word oriented
    typedef struct packed {
        logic         req;
        logic         wr;
        access_size_t size;
        addr_t        addr;
        word_t        wdata;
    } sram_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } sram_resp_t;

    // burst side, addr is line aligned
    typedef struct packed {
        logic        valid;
        logic        is_write;
        cbus_order_t order;
        addr_t       addr;
        word_t       wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        RESERVED
    } buffer_state_t;

    // byte lanes touched by one access
    function automatic strobe_t size_to_strobe(access_size_t size, index_t index);
        strobe_t strobe;
        case (size)
            BYTE:    strobe = strobe_t'(4'b0001 << index);
            HALF:    strobe = strobe_t'(4'b0011 << {index[1], 1'b0});
            default: strobe = '1;
        endcase
        return strobe;
    endfunction

endpackage

`default_nettype wire

// File: source/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// data path width in bits
`define CACHE_WORD_BITS 32

// one buffer line, in words
`define CACHE_LINE_WORDS 16

// log2 of the line length, sent as the burst order
`define CACHE_BURST_ORDER 4

// backing RAM depth in words, higher addresses wrap around
`define CACHE_RAM_WORDS 1024

`endif
